/* Makefile */
SIM := obj_dir/Vrv_core_tb

.PHONY: all run clean

all: run

$(SIM): filelist.f $(wildcard src/*.sv) $(wildcard verif/*.sv)
	verilator --binary --timing --assert --top-module rv_core_tb -f filelist.f

run: $(SIM)
	$(SIM) | tee sim.log
	grep -q "Everything OK" sim.log

clean:
	rm -rf obj_dir sim.log

/* filelist.f */
src/rv_pkg.sv
src/rv_decoder.sv
src/rv_regfile.sv
src/rv_alu.sv
src/rv_pc_unit.sv
src/rv_core.sv
verif/rv_core_tb.sv

/* src/rv_alu.sv */
`timescale 1ns/1ns
`default_nettype none

module rv_alu (
  input  rv_pkg::ctrl_t ctrl,
  input  rv_pkg::word_t pc,
  input  rv_pkg::word_t rs1_data,
  input  rv_pkg::word_t rs2_data,
  input  rv_pkg::word_t imm,
  output rv_pkg::word_t result
);

  rv_pkg::word_t op_a;
  rv_pkg::word_t op_b;
  logic [4:0]    shamt;

  // pc feeds auipc, immediate feeds the i and s forms
  assign op_a  = ctrl.srcs_pc ? pc : rs1_data;
  assign op_b  = ctrl.src_imm ? imm : rs2_data;
  assign shamt = op_b[4:0];

  always_comb begin
    case (ctrl.alu_op)
      rv_pkg::alu_add: result = op_a + op_b;
      rv_pkg::alu_sub: result = op_a - op_b;
      rv_pkg::alu_sll: result = op_a << shamt;
      rv_pkg::alu_slt: begin
        result = {31'd0, $signed(op_a) < $signed(op_b)};
      end
      rv_pkg::alu_sltu: result = {31'd0, op_a < op_b};
      rv_pkg::alu_xor: result = op_a ^ op_b;
      rv_pkg::alu_srl: result = op_a >> shamt;
      // sign bit fills from the left
      rv_pkg::alu_sra: result = $unsigned($signed(op_a) >>> shamt);
      rv_pkg::alu_or: result = op_a | op_b;
      rv_pkg::alu_and: result = op_a & op_b;
      default: result = op_a + op_b;
    endcase
  end

endmodule

`default_nettype wire

/* src/rv_core.sv */
`timescale 1ns/1ns
`default_nettype none

module rv_core #(
  parameter rv_pkg::word_t reset_pc = 32'h0000_0000
) (
  input  logic              clk,
  input  logic              rst,
  output rv_pkg::word_t     pc,
  input  rv_pkg::insn_t     insn,
  output rv_pkg::dmem_req_t dmem_req,
  input  rv_pkg::word_t     load_data,
  output logic              halt
);

  rv_pkg::ctrl_t    ctrl;
  rv_pkg::word_t    imm;
  rv_pkg::reg_idx_t rd;
  rv_pkg::reg_idx_t rs1;
  rv_pkg::reg_idx_t rs2;
  rv_pkg::word_t    rs1_data;
  rv_pkg::word_t    rs2_data;
  rv_pkg::word_t    alu_result;
  rv_pkg::word_t    pc_plus4;
  rv_pkg::word_t    rd_data;

  rv_decoder i_rv_decoder (
    .insn (insn),
    .ctrl (ctrl),
    .imm  (imm),
    .rd   (rd),
    .rs1  (rs1),
    .rs2  (rs2)
  );

  rv_regfile i_rv_regfile (
    .clk      (clk),
    .rst      (rst),
    .rs1      (rs1),
    .rs2      (rs2),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .rd       (rd),
    .rd_we    (ctrl.rd_we),
    .rd_data  (rd_data)
  );

  rv_alu i_rv_alu (
    .ctrl     (ctrl),
    .pc       (pc),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .imm      (imm),
    .result   (alu_result)
  );

  rv_pc_unit #(
    .reset_pc (reset_pc)
  ) i_rv_pc_unit (
    .clk      (clk),
    .rst      (rst),
    .ctrl     (ctrl),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .imm      (imm),
    .pc       (pc),
    .pc_plus4 (pc_plus4)
  );

  // write-back source
  always_comb begin
    case (ctrl.rd_src)
      rv_pkg::rd_src_load: rd_data = load_data;
      rv_pkg::rd_src_pc4: rd_data = pc_plus4;
      default: rd_data = alu_result;
    endcase
  end

  // loads and stores share the alu address
  assign dmem_req.addr  = alu_result;
  assign dmem_req.wdata = rs2_data;
  assign dmem_req.we    = {4{ctrl.mem_we}};

  assign halt = ctrl.halt;

endmodule

`default_nettype wire

/* src/rv_decoder.sv */
`timescale 1ns/1ns
`default_nettype none

module rv_decoder (
  input  rv_pkg::insn_t    insn,
  output rv_pkg::ctrl_t    ctrl,
  output rv_pkg::word_t    imm,
  output rv_pkg::reg_idx_t rd,
  output rv_pkg::reg_idx_t rs1,
  output rv_pkg::reg_idx_t rs2
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  logic       is_shift;
  logic       alt_ok;
  logic       alu_legal;

  assign opcode = insn.r.opcode;
  assign funct3 = insn.r.funct3;
  assign funct7 = insn.r.funct7;

  assign rd  = insn.r.rd;
  // lui adds its immediate to x0
  assign rs1 = (opcode == rv_pkg::op_lui) ? '0 : insn.r.rs1;
  assign rs2 = insn.r.rs2;

  // funct7 check for the alu groups
  assign is_shift = (funct3 == rv_pkg::f3_sll) || (funct3 == rv_pkg::f3_sr);
  assign alt_ok = (funct3 == rv_pkg::f3_sr) ||
                  ((opcode == rv_pkg::op_reg_reg) && (funct3 == rv_pkg::f3_add));
  always_comb begin
    if ((opcode == rv_pkg::op_reg_imm) && !is_shift) begin
      alu_legal = 1'b1;
    end else begin
      alu_legal = (funct7 == rv_pkg::f7_base) || ((funct7 == rv_pkg::f7_alt) && alt_ok);
    end
  end

  // immediate by format
  always_comb begin
    case (opcode)
      rv_pkg::op_lui, rv_pkg::op_auipc: imm = {insn.u.imm, 12'b0};
      rv_pkg::op_jal: imm = {{11{insn.j.imm_20}}, insn.j.imm_20, insn.j.imm_19_12,
                             insn.j.imm_11, insn.j.imm_10_1, 1'b0};
      rv_pkg::op_branch: imm = {{19{insn.b.imm_12}}, insn.b.imm_12, insn.b.imm_11,
                                insn.b.imm_10_5, insn.b.imm_4_1, 1'b0};
      rv_pkg::op_store: imm = {{20{insn.s.imm_hi[6]}}, insn.s.imm_hi, insn.s.imm_lo};
      default: imm = {{20{insn.i.imm[11]}}, insn.i.imm};
    endcase
  end

  always_comb begin
    ctrl = '0;
    ctrl.alu_op = rv_pkg::alu_add;
    ctrl.rd_src = rv_pkg::rd_src_alu;
    ctrl.br_kind = rv_pkg::br_none;
    ctrl.funct3 = funct3;
    case (opcode)
      rv_pkg::op_lui: begin
        ctrl.src_imm = 1'b1;
        ctrl.rd_we = 1'b1;
      end
      rv_pkg::op_auipc: begin
        ctrl.srcs_pc = 1'b1;
        ctrl.src_imm = 1'b1;
        ctrl.rd_we = 1'b1;
      end
      rv_pkg::op_jal: begin
        ctrl.rd_we = 1'b1;
        ctrl.rd_src = rv_pkg::rd_src_pc4;
        ctrl.br_kind = rv_pkg::br_jal;
      end
      rv_pkg::op_jalr: begin
        ctrl.rd_we = 1'b1;
        ctrl.rd_src = rv_pkg::rd_src_pc4;
        ctrl.br_kind = rv_pkg::br_jalr;
      end
      rv_pkg::op_branch: begin
        // funct3 010 and 011 are not branches
        if (funct3[2:1] != 2'b01) begin
          ctrl.br_kind = rv_pkg::br_cond;
        end
      end
      rv_pkg::op_load: begin
        ctrl.src_imm = 1'b1;
        ctrl.rd_we = (funct3 == rv_pkg::f3_word);
        ctrl.rd_src = rv_pkg::rd_src_load;
      end
      rv_pkg::op_store: begin
        ctrl.src_imm = 1'b1;
        ctrl.mem_we = (funct3 == rv_pkg::f3_word);
      end
      rv_pkg::op_reg_imm, rv_pkg::op_reg_reg: begin
        ctrl.src_imm = (opcode == rv_pkg::op_reg_imm);
        ctrl.rd_we = alu_legal;
        case (funct3)
          rv_pkg::f3_add: begin
            ctrl.alu_op = (opcode == rv_pkg::op_reg_reg && funct7[5]) ?
                          rv_pkg::alu_sub : rv_pkg::alu_add;
          end
          rv_pkg::f3_sll: ctrl.alu_op = rv_pkg::alu_sll;
          rv_pkg::f3_slt: ctrl.alu_op = rv_pkg::alu_slt;
          rv_pkg::f3_sltu: ctrl.alu_op = rv_pkg::alu_sltu;
          rv_pkg::f3_xor: ctrl.alu_op = rv_pkg::alu_xor;
          rv_pkg::f3_sr: ctrl.alu_op = funct7[5] ? rv_pkg::alu_sra : rv_pkg::alu_srl;
          rv_pkg::f3_or: ctrl.alu_op = rv_pkg::alu_or;
          rv_pkg::f3_and: ctrl.alu_op = rv_pkg::alu_and;
        endcase
      end
      rv_pkg::op_system: begin
        // ecall is the all-zero encoding above the opcode
        ctrl.halt = (insn[31:7] == 25'd0);
      end
      default: begin
        ctrl.rd_we = 1'b0;
      end
    endcase
  end

endmodule

`default_nettype wire

/* src/rv_pc_unit.sv */
`timescale 1ns/1ns
`default_nettype none

module rv_pc_unit #(
  parameter rv_pkg::word_t reset_pc = '0
) (
  input  logic          clk,
  input  logic          rst,
  input  rv_pkg::ctrl_t ctrl,
  input  rv_pkg::word_t rs1_data,
  input  rv_pkg::word_t rs2_data,
  input  rv_pkg::word_t imm,
  output rv_pkg::word_t pc,
  output rv_pkg::word_t pc_plus4
);

  logic          taken;
  rv_pkg::word_t jalr_target;
  rv_pkg::word_t next_pc;

  assign pc_plus4 = pc + 32'd4;
  assign jalr_target = (rs1_data + imm) & ~32'd1;

  // branch condition
  always_comb begin
    case (ctrl.funct3)
      rv_pkg::f3_beq: taken = (rs1_data == rs2_data);
      rv_pkg::f3_bne: taken = (rs1_data != rs2_data);
      rv_pkg::f3_blt: taken = ($signed(rs1_data) < $signed(rs2_data));
      rv_pkg::f3_bge: taken = ($signed(rs1_data) >= $signed(rs2_data));
      rv_pkg::f3_bltu: taken = (rs1_data < rs2_data);
      rv_pkg::f3_bgeu: taken = (rs1_data >= rs2_data);
      default: taken = 1'b0;
    endcase
  end

  always_comb begin
    case (ctrl.br_kind)
      rv_pkg::br_cond: next_pc = taken ? (pc + imm) : pc_plus4;
      rv_pkg::br_jal: next_pc = pc + imm;
      rv_pkg::br_jalr: next_pc = jalr_target;
      default: next_pc = pc_plus4;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      pc <= reset_pc;
    end else begin
      pc <= next_pc;
    end
  end

endmodule

`default_nettype wire

/* src/rv_pkg.sv */
`default_nettype none

package rv_pkg;

  localparam int xlen = 32;
  localparam int reg_addr_w = 5;

  // base opcodes
  localparam logic [6:0] op_lui = 7'b0110111;
  localparam logic [6:0] op_auipc = 7'b0010111;
  localparam logic [6:0] op_jal = 7'b1101111;
  localparam logic [6:0] op_jalr = 7'b1100111;
  localparam logic [6:0] op_branch = 7'b1100011;
  localparam logic [6:0] op_load = 7'b0000011;
  localparam logic [6:0] op_store = 7'b0100011;
  localparam logic [6:0] op_reg_imm = 7'b0010011;
  localparam logic [6:0] op_reg_reg = 7'b0110011;
  localparam logic [6:0] op_system = 7'b1110011;

  // branch conditions
  localparam logic [2:0] f3_beq = 3'b000;
  localparam logic [2:0] f3_bne = 3'b001;
  localparam logic [2:0] f3_blt = 3'b100;
  localparam logic [2:0] f3_bge = 3'b101;
  localparam logic [2:0] f3_bltu = 3'b110;
  localparam logic [2:0] f3_bgeu = 3'b111;

  // arithmetic and shift group
  localparam logic [2:0] f3_add = 3'b000;
  localparam logic [2:0] f3_sll = 3'b001;
  localparam logic [2:0] f3_slt = 3'b010;
  localparam logic [2:0] f3_sltu = 3'b011;
  localparam logic [2:0] f3_xor = 3'b100;
  localparam logic [2:0] f3_sr = 3'b101;
  localparam logic [2:0] f3_or = 3'b110;
  localparam logic [2:0] f3_and = 3'b111;

  // only full-word memory access
  localparam logic [2:0] f3_word = 3'b010;

  localparam logic [6:0] f7_base = 7'b0000000;
  localparam logic [6:0] f7_alt = 7'b0100000;

  typedef logic [xlen-1:0] word_t;
  typedef logic [reg_addr_w-1:0] reg_idx_t;

  typedef struct packed {
    logic [6:0] funct7;
    reg_idx_t   rs2;
    reg_idx_t   rs1;
    logic [2:0] funct3;
    reg_idx_t   rd;
    logic [6:0] opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0] imm;
    reg_idx_t    rs1;
    logic [2:0]  funct3;
    reg_idx_t    rd;
    logic [6:0]  opcode;
  } i_fmt_t;

  typedef struct packed {
    logic [6:0] imm_hi;
    reg_idx_t   rs2;
    reg_idx_t   rs1;
    logic [2:0] funct3;
    logic [4:0] imm_lo;
    logic [6:0] opcode;
  } s_fmt_t;

  typedef struct packed {
    logic       imm_12;
    logic [5:0] imm_10_5;
    reg_idx_t   rs2;
    reg_idx_t   rs1;
    logic [2:0] funct3;
    logic [3:0] imm_4_1;
    logic       imm_11;
    logic [6:0] opcode;
  } b_fmt_t;

  typedef struct packed {
    logic [19:0] imm;
    reg_idx_t    rd;
    logic [6:0]  opcode;
  } u_fmt_t;

  typedef struct packed {
    logic       imm_20;
    logic [9:0] imm_10_1;
    logic       imm_11;
    logic [7:0] imm_19_12;
    reg_idx_t   rd;
    logic [6:0] opcode;
  } j_fmt_t;

  // same 32 bits, six readings
  typedef union packed {
    r_fmt_t r;
    i_fmt_t i;
    s_fmt_t s;
    b_fmt_t b;
    u_fmt_t u;
    j_fmt_t j;
  } insn_t;

  typedef enum logic [3:0] {
    alu_add, alu_sub, alu_sll, alu_slt, alu_sltu,
    alu_xor, alu_srl, alu_sra, alu_or, alu_and
  } alu_op_t;

  typedef enum logic [1:0] {br_none, br_cond, br_jal, br_jalr} br_kind_t;

  typedef enum logic [1:0] {rd_src_alu, rd_src_load, rd_src_pc4} rd_src_t;

  typedef struct packed {
    alu_op_t    alu_op;
    logic       srcs_pc;
    logic       src_imm;
    logic       rd_we;
    rd_src_t    rd_src;
    logic       mem_we;
    br_kind_t   br_kind;
    logic [2:0] funct3;
    logic       halt;
  } ctrl_t;

  typedef struct packed {
    word_t      addr;
    word_t      wdata;
    logic [3:0] we;
  } dmem_req_t;

endpackage

`default_nettype wire

/* src/rv_regfile.sv */
`timescale 1ns/1ns
`default_nettype none

module rv_regfile (
  input  logic             clk,
  input  logic             rst,
  input  rv_pkg::reg_idx_t rs1,
  input  rv_pkg::reg_idx_t rs2,
  output rv_pkg::word_t    rs1_data,
  output rv_pkg::word_t    rs2_data,
  input  rv_pkg::reg_idx_t rd,
  input  logic             rd_we,
  input  rv_pkg::word_t    rd_data
);

  // x0 has no storage
  rv_pkg::word_t regs [1:31];

  assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
  assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (rd_we && (rd != '0)) begin
      regs[rd] <= rd_data;
    end
  end

endmodule

`default_nettype wire

/* verif/rv_core_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module rv_core_tb;

  localparam rv_pkg::word_t reset_pc = 32'h0000_0100;
  localparam logic [31:0] nop_word = 32'h0000_0013;
  localparam logic [31:0] ecall_word = 32'h0000_0073;

  logic              clk;
  logic              rst;
  rv_pkg::word_t     pc;
  rv_pkg::insn_t     insn;
  rv_pkg::dmem_req_t dmem_req;
  rv_pkg::word_t     load_data;
  logic              halt;

  logic [31:0] imem [0:1023];
  logic [31:0] dmem [0:1023];
  // expected pc after the instruction at each word slot
  logic [31:0] exp_next [0:1023];
  logic [31:0] model [0:31];
  logic [31:0] exp_wdata [$];
  logic [31:0] exp_addr [$];
  string       test_name [$];
  logic [31:0] test_start [$];

  integer      seed;
  logic [31:0] prog_pc;
  logic [31:0] halt_pc;
  logic [31:0] prev_pc;
  logic [11:0] store_addr;
  logic [11:0] last_addr;
  int          prog_len;
  int          errors;
  int          test_err_base;
  int          cur_test;
  int          pass_cnt;
  int          fail_cnt;
  int          cycles;
  int          cycle_limit;
  logic        done;

  rv_core #(
    .reset_pc (reset_pc)
  ) i_rv_core (
    .clk       (clk),
    .rst       (rst),
    .pc        (pc),
    .insn      (insn),
    .dmem_req  (dmem_req),
    .load_data (load_data),
    .halt      (halt)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // nop while in reset, pc is not valid yet
  assign insn = rst ? nop_word : imem[pc[11:2]];
  assign load_data = dmem[dmem_req.addr[11:2]];

  always @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < 1024; i++) begin
        dmem[i] <= {i[15:0] ^ 16'h5a5a, ~i[15:0]};
      end
    end else if (dmem_req.we == 4'hf) begin
      dmem[dmem_req.addr[11:2]] <= dmem_req.wdata;
    end
  end

  function automatic logic [31:0] enc_r(input logic [6:0] f7, input int rs2, input int rs1,
                                        input logic [2:0] f3, input int rd);
    return {f7, rs2[4:0], rs1[4:0], f3, rd[4:0], rv_pkg::op_reg_reg};
  endfunction

  function automatic logic [31:0] enc_i(input logic [11:0] imm, input int rs1,
                                        input logic [2:0] f3, input int rd,
                                        input logic [6:0] op);
    return {imm, rs1[4:0], f3, rd[4:0], op};
  endfunction

  function automatic logic [31:0] enc_s(input logic [11:0] imm, input int rs2, input int rs1,
                                        input logic [2:0] f3);
    return {imm[11:5], rs2[4:0], rs1[4:0], f3, imm[4:0], rv_pkg::op_store};
  endfunction

  function automatic logic [31:0] enc_b(input logic [12:0] off, input int rs2, input int rs1,
                                        input logic [2:0] f3);
    return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3, off[4:1], off[11], rv_pkg::op_branch};
  endfunction

  function automatic logic [31:0] enc_u(input logic [19:0] imm, input int rd,
                                        input logic [6:0] op);
    return {imm, rd[4:0], op};
  endfunction

  function automatic logic [31:0] enc_j(input logic [20:0] off, input int rd);
    return {off[20], off[10:1], off[11], off[19:12], rd[4:0], rv_pkg::op_jal};
  endfunction

  function automatic logic less_signed(input logic [31:0] a, input logic [31:0] b);
    // differing signs decide on their own
    return (a[31] != b[31]) ? a[31] : (a < b);
  endfunction

  function automatic logic [31:0] ref_alu(input logic [2:0] f3, input logic alt,
                                          input logic [31:0] a, input logic [31:0] b);
    logic [4:0] sh;
    sh = b[4:0];
    case (f3)
      3'b000: return alt ? a - b : a + b;
      3'b001: return a << sh;
      3'b010: return {31'd0, less_signed(a, b)};
      3'b011: return {31'd0, a < b};
      3'b100: return a ^ b;
      3'b101: return (a >> sh) | ((alt && a[31]) ? ~(32'hffff_ffff >> sh) : 32'd0);
      3'b110: return a | b;
      default: return a & b;
    endcase
  endfunction

  function automatic logic br_taken(input logic [2:0] f3, input logic [31:0] a,
                                    input logic [31:0] b);
    case (f3)
      3'b000: return a == b;
      3'b001: return a != b;
      3'b100: return less_signed(a, b);
      3'b101: return !less_signed(a, b);
      3'b110: return a < b;
      default: return !(a < b);
    endcase
  endfunction

  task automatic mismatch(input string msg);
    $display("Mismatch at %0t: %s", $time, msg);
    errors++;
  endtask

  task automatic put(input logic [31:0] word, input logic [31:0] nxt);
    imem[prog_pc[11:2]] = word;
    exp_next[prog_pc[11:2]] = nxt;
    prog_pc = prog_pc + 32'd4;
    prog_len++;
  endtask

  task automatic put_seq(input logic [31:0] word);
    put(word, prog_pc + 32'd4);
  endtask

  task automatic set_reg(input int rd, input logic [31:0] val);
    if (rd != 0) begin
      model[rd] = val;
    end
  endtask

  task automatic op_imm(input logic [2:0] f3, input int rd, input int rs1,
                        input logic [11:0] imm);
    logic alt;
    alt = (f3 == rv_pkg::f3_sr) && imm[10];
    put_seq(enc_i(imm, rs1, f3, rd, rv_pkg::op_reg_imm));
    set_reg(rd, ref_alu(f3, alt, model[rs1], {{20{imm[11]}}, imm}));
  endtask

  task automatic op_reg(input logic [2:0] f3, input logic alt, input int rd, input int rs1,
                        input int rs2);
    put_seq(enc_r(alt ? rv_pkg::f7_alt : rv_pkg::f7_base, rs2, rs1, f3, rd));
    set_reg(rd, ref_alu(f3, alt, model[rs1], model[rs2]));
  endtask

  task automatic lui(input int rd, input logic [19:0] imm);
    put_seq(enc_u(imm, rd, rv_pkg::op_lui));
    set_reg(rd, {imm, 12'd0});
  endtask

  task automatic store_reg(input int rs2);
    put_seq(enc_s(store_addr, rs2, 0, rv_pkg::f3_word));
    exp_wdata.push_back(model[rs2]);
    exp_addr.push_back({20'd0, store_addr});
    last_addr = store_addr;
    store_addr = store_addr + 12'd4;
  endtask

  task automatic branch_case(input logic [2:0] f3, input int rs1, input int rs2);
    logic taken;
    taken = br_taken(f3, model[rs1], model[rs2]);
    put(enc_b(13'd8, rs2, rs1, f3), taken ? prog_pc + 32'd8 : prog_pc + 32'd4);
    // x7 counts the not-taken fall-throughs
    put_seq(enc_i(12'd1, 7, rv_pkg::f3_add, 7, rv_pkg::op_reg_imm));
    if (!taken) begin
      set_reg(7, model[7] + 32'd1);
    end
  endtask

  task automatic begin_test(input string name);
    test_name.push_back(name);
    test_start.push_back(prog_pc);
  endtask

  task automatic build_program();
    logic [31:0] r;
    logic [31:0] p;
    logic [31:0] poison;
    logic [19:0] a_hi;
    logic [19:0] b_hi;
    logic [11:0] a_lo;
    logic [11:0] b_lo;
    for (int i = 0; i < 1024; i++) begin
      imem[i] = nop_word;
      exp_next[i] = 32'd0;
    end
    for (int i = 0; i < 32; i++) begin
      model[i] = 32'd0;
    end
    prog_pc = reset_pc;
    prog_len = 0;
    store_addr = 12'h400;
    // never executed when the flow is right
    poison = enc_i(12'd1, 9, rv_pkg::f3_add, 9, rv_pkg::op_reg_imm);

    begin_test("reset");
    r = $random(seed);
    op_imm(rv_pkg::f3_add, 1, 0, r[11:0]);
    op_imm(rv_pkg::f3_xor, 2, 1, r[23:12]);
    store_reg(2);

    // x3 negative, x4 positive with a nonzero shift amount
    begin_test("alu");
    r = $random(seed);
    a_hi = r[19:0] | 20'h80010;
    a_lo = r[31:20];
    r = $random(seed);
    b_hi = (r[19:0] & 20'h7ffff) | 20'h00010;
    b_lo = r[31:20] | 12'h001;
    lui(3, a_hi);
    op_imm(rv_pkg::f3_add, 3, 3, a_lo);
    lui(4, b_hi);
    op_imm(rv_pkg::f3_add, 4, 4, b_lo);
    store_reg(3);
    store_reg(4);
    for (int f = 0; f < 8; f++) begin
      op_reg(f[2:0], 1'b0, 5, 3, 4);
      store_reg(5);
    end
    op_reg(rv_pkg::f3_add, 1'b1, 5, 3, 4);
    store_reg(5);
    op_reg(rv_pkg::f3_sr, 1'b1, 5, 3, 4);
    store_reg(5);
    for (int f = 0; f < 8; f++) begin
      r = $random(seed);
      if (f == 1 || f == 5) begin
        op_imm(f[2:0], 6, 3, {7'd0, r[4:0] | 5'd1});
      end else begin
        op_imm(f[2:0], 6, 3, r[11:0]);
      end
      store_reg(6);
    end
    r = $random(seed);
    op_imm(rv_pkg::f3_sr, 6, 3, {rv_pkg::f7_alt, r[4:0] | 5'd1});
    store_reg(6);

    // equal, negative-positive and positive-negative pairs
    begin_test("branch");
    op_imm(rv_pkg::f3_add, 6, 3, 12'd0);
    for (int f = 0; f < 8; f++) begin
      if (f[2:1] != 2'b01) begin
        branch_case(f[2:0], 3, 6);
        branch_case(f[2:0], 3, 4);
        branch_case(f[2:0], 4, 3);
      end
    end
    store_reg(7);

    begin_test("jump");
    set_reg(8, prog_pc + 32'd4);
    put(enc_j(21'd8, 8), prog_pc + 32'd8);
    put_seq(poison);
    store_reg(8);
    p = prog_pc;
    op_imm(rv_pkg::f3_add, 10, 0, p[11:0] + 12'd8);
    set_reg(11, prog_pc + 32'd4);
    // base plus 5 is odd, target drops bit 0
    put(enc_i(12'd5, 10, 3'b000, 11, rv_pkg::op_jalr), p + 32'd12);
    put_seq(poison);
    store_reg(11);
    r = $random(seed);
    set_reg(12, prog_pc + {r[19:0], 12'd0});
    put_seq(enc_u(r[19:0], 12, rv_pkg::op_auipc));
    store_reg(12);

    begin_test("memory");
    store_reg(3);
    put_seq(enc_i(last_addr, 0, rv_pkg::f3_word, 13, rv_pkg::op_load));
    set_reg(13, model[3]);
    store_reg(13);
    r = $random(seed);
    op_imm(rv_pkg::f3_add, 0, 4, r[11:0] | 12'h001);
    lui(0, r[31:12]);
    op_reg(rv_pkg::f3_add, 1'b0, 0, 3, 4);
    store_reg(0);

    begin_test("halt");
    halt_pc = prog_pc;
    put_seq(ecall_word);
    cycle_limit = 4 * prog_len + 50;
  endtask

  task automatic close_test();
    if (cur_test < test_name.size()) begin
      if (errors == test_err_base) begin
        pass_cnt++;
        $display("test %s passed", test_name[cur_test]);
      end else begin
        fail_cnt++;
        $display("test %s failed with %0d errors", test_name[cur_test], errors - test_err_base);
      end
      test_err_base = errors;
    end
  endtask

  task automatic check_reset_state();
    assert (pc == reset_pc) else
      mismatch($sformatf("pc 0x%08h, expected reset pc 0x%08h", pc, reset_pc));
    assert (dmem_req.we == 4'h0) else
      mismatch($sformatf("store enable 0x%h near reset", dmem_req.we));
    assert (!halt) else
      mismatch("halt raised near reset");
  endtask

  task automatic check_cycle();
    logic [31:0] w;
    logic [31:0] a;
    assert (pc == exp_next[prev_pc[11:2]]) else
      mismatch($sformatf("pc 0x%08h after 0x%08h, expected 0x%08h",
                         pc, prev_pc, exp_next[prev_pc[11:2]]));
    prev_pc = pc;
    if (cur_test + 1 < test_start.size() && pc == test_start[cur_test + 1]) begin
      close_test();
      cur_test++;
    end
    if (dmem_req.we != 4'h0) begin
      if (exp_wdata.size() == 0) begin
        $display("store at pc 0x%08h was not expected", pc);
        errors++;
      end else begin
        w = exp_wdata.pop_front();
        a = exp_addr.pop_front();
        assert (dmem_req.we == 4'hf) else
          mismatch($sformatf("store enable 0x%h, expected 0xf", dmem_req.we));
        assert (dmem_req.addr == a) else
          mismatch($sformatf("store address 0x%08h, expected 0x%08h", dmem_req.addr, a));
        assert (dmem_req.wdata == w) else
          mismatch($sformatf("store data 0x%08h, expected 0x%08h at pc 0x%08h",
                             dmem_req.wdata, w, pc));
      end
    end
    assert (halt == (pc == halt_pc)) else
      mismatch($sformatf("halt %0b at pc 0x%08h, ecall is at 0x%08h", halt, pc, halt_pc));
    if (halt || pc == halt_pc) begin
      close_test();
      done = 1'b1;
    end
  endtask

  initial begin
    seed = 32'ha8f94314;
    rst = 1'b1;
    errors = 0;
    test_err_base = 0;
    cur_test = 0;
    pass_cnt = 0;
    fail_cnt = 0;
    cycles = 0;
    done = 1'b0;
    build_program();
    repeat (2) begin
      @(negedge clk);
      check_reset_state();
    end
    rst = 1'b0;
    // first cycle out of reset
    #10;
    check_reset_state();
    prev_pc = reset_pc;
    while (!done) begin
      @(negedge clk);
      cycles++;
      check_cycle();
      if (!done && cycles >= cycle_limit) begin
        $display("timeout: halt was not raised within %0d cycles", cycle_limit);
        errors++;
        close_test();
        done = 1'b1;
      end
    end
    if (exp_wdata.size() != 0) begin
      $display("%0d expected stores were never issued", exp_wdata.size());
      errors++;
    end
    $display("tests passed: %0d, tests failed: %0d, errors: %0d", pass_cnt, fail_cnt, errors);
    if (errors == 0 && fail_cnt == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
